// File: common/gb_cart_defs.svh
// Fixed console widths and header offsets; the ROM store is word addressed, downloads are byte addressed
`ifndef GB_CART_DEFS_SVH
`define GB_CART_DEFS_SVH

// --------------------
// Bus widths
// --------------------
`define CART_ADDR_W     16      // CPU address bus
`define ROM_WADDR_W     24      // External ROM store, 16-bit words
`define DL_ADDR_W       25      // Download byte address
`define ROM_BANK_W      9       // Up to 512 ROM banks (MBC5)
`define RAM_BANK_W      4       // Up to 16 RAM banks of 8 KB
`define CRAM_ADDR_W     17      // 128 KB cartridge RAM

// --------------------
// Cartridge header
// --------------------
// Both offsets are even, so each field arrives in one download word
`define HDR_TYPE_ADDR   25'h146 // Controller type in high byte
`define HDR_SIZE_ADDR   25'h148 // RAM size high, ROM size low

// --------------------
// Register writes
// --------------------
`define RAM_ENABLE_KEY  4'hA    // Low nibble that opens the RAM

// CPU address bits 15..13 of the A000-BFFF RAM window
`define CRAM_WINDOW     3'b101

`endif

// File: common/gb_cart_pkg.sv
// Types shared by the cartridge blocks; only the five supported controllers are decoded
package gb_cart_pkg;

	// --------------------
	// Controller kind
	// --------------------
	// Decoded once from the header type byte, everything
	// downstream switches on this instead of raw type codes
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0,  // 32 KB ROM, no banking
		MBC_1    = 3'd1,  // 5+2 bit ROM bank, mode bit
		MBC_2    = 3'd2,  // Built-in 512x4 RAM
		MBC_3    = 3'd3,  // 7 bit ROM bank, clock registers
		MBC_5    = 3'd4   // 9 bit ROM bank, 16 RAM banks
	} mbc_kind_t;

	// --------------------
	// Register select
	// --------------------
	// CPU stores to 0000-7FFF hit the controller registers.
	// Address bits 14..13 pick the register, bit 15 is zero
	// for the whole range so it is left out of the opcode
	typedef enum logic [1:0] {
		SEL_RAM_EN   = 2'b00,  // 0000-1FFF
		SEL_ROM_BANK = 2'b01,  // 2000-3FFF
		SEL_RAM_BANK = 2'b10,  // 4000-5FFF
		SEL_MODE     = 2'b11   // 6000-7FFF
	} reg_sel_t;

endpackage

// File: verilog/cart_header.sv
// Captures header bytes only while dl_active is high; fields stay valid until the next download or reset
`timescale 1ns/10ps
`include "gb_cart_defs.svh"

module cart_header import gb_cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  logic [`DL_ADDR_W-1:0]  dl_addr,
	input  logic [15:0]            dl_data,
	output mbc_kind_t              mbc_kind,
	output logic [`ROM_BANK_W-1:0] rom_mask,
	output logic [`RAM_BANK_W-1:0] ram_mask,
	output logic                   has_ram
);

	logic [7:0] cart_type;  // Header byte 147
	logic [7:0] rom_size;   // Header byte 148
	logic [7:0] ram_size;   // Header byte 149

	// --------------------
	// Capture
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
		end else if (dl_active && dl_wr) begin
			if (dl_addr == `HDR_TYPE_ADDR)
				cart_type <= dl_data[15:8];  // Odd byte sits in the high half
			if (dl_addr == `HDR_SIZE_ADDR) begin
				ram_size <= dl_data[15:8];
				rom_size <= dl_data[7:0];
			end
		end
	end

	// --------------------
	// Decode
	// --------------------
	always_comb begin
		case (cart_type) inside
			[8'h01:8'h03]: mbc_kind = MBC_1;
			[8'h05:8'h06]: mbc_kind = MBC_2;
			[8'h0F:8'h13]: mbc_kind = MBC_3;  // Includes timer variants
			[8'h19:8'h1E]: mbc_kind = MBC_5;  // Includes rumble variants
			default:       mbc_kind = MBC_NONE;
		endcase
	end

	// Code n means 2^(n+1) banks of 16 KB
	always_comb begin
		if (rom_size <= 8'd8)
			rom_mask = 9'h1FF >> (4'd8 - rom_size[3:0]);
		else
			rom_mask = 9'd127;  // Odd sizes 52-54 map into 128 banks
	end

	// 2 KB and 8 KB fit one bank, 32 KB is four banks
	assign ram_mask = (ram_size <= 8'd2) ? 4'b0000 :
	                  (ram_size == 8'd3) ? 4'b0011 :
	                                       4'b1111;

	// MBC2 has its RAM inside the controller, size code is zero there
	assign has_ram = (ram_size != 8'h00) || (mbc_kind == MBC_2);

endmodule

// File: mapper/mbc_bank_regs.sv
// Registers change only on cycles with ce_cpu2x high; writes to 8000-FFFF are ignored here
`timescale 1ns/10ps
`include "gb_cart_defs.svh"

module mbc_bank_regs import gb_cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   ce_cpu2x,
	input  logic                   cart_wr,
	input  logic [`CART_ADDR_W-1:0] cart_addr,
	input  logic [7:0]             cart_di,
	input  mbc_kind_t              mbc_kind,
	output logic [`ROM_BANK_W-1:0] rom_bank,
	output logic [`RAM_BANK_W-1:0] ram_bank,
	output logic                   mbc1_mode,
	output logic                   rtc_mode,
	output logic                   ram_enable
);

	reg_sel_t reg_sel;
	logic     reg_wr;

	// Store to 0000-7FFF, bit 15 low
	assign reg_sel = reg_sel_t'(cart_addr[14:13]);
	assign reg_wr  = ce_cpu2x && cart_wr && !cart_addr[15];

	// --------------------
	// Register file
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank   <= 9'd1;  // Bank 0 is always at 0000, start at 1
			ram_bank   <= 4'd0;
			mbc1_mode  <= 1'b0;
			rtc_mode   <= 1'b0;
			ram_enable <= 1'b0;
		end else if (reg_wr) begin
			case (reg_sel)
				SEL_RAM_EN: begin
					ram_enable <= (cart_di[3:0] == `RAM_ENABLE_KEY);
				end

				SEL_ROM_BANK: begin
					if (mbc_kind == MBC_5) begin
						// MBC5 splits the register, 3000-3FFF holds bit 8
						if (cart_addr[12])
							rom_bank[8] <= cart_di[0];
						else
							rom_bank[7:0] <= cart_di;
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank <= 9'd1;  // Older MBCs cannot select bank 0 here
					end else begin
						rom_bank <= {2'b00, cart_di[6:0]};
					end
				end

				SEL_RAM_BANK: begin
					if (mbc_kind == MBC_3) begin
						// Values 08-0C select a clock register instead of RAM
						if (cart_di[3]) begin
							rtc_mode <= 1'b1;
						end else begin
							rtc_mode <= 1'b0;
							ram_bank <= {2'b00, cart_di[1:0]};
						end
					end else if (mbc_kind == MBC_5) begin
						ram_bank <= cart_di[3:0];  // 16 banks
					end else begin
						ram_bank <= {2'b00, cart_di[1:0]};  // MBC1 also uses these as ROM bits
					end
				end

				SEL_MODE: begin
					if (mbc_kind == MBC_1)
						mbc1_mode <= cart_di[0];  // 1 means RAM banking mode
				end

				default: ;
			endcase
		end
	end

endmodule

// File: mapper/rom_addr_map.sv
// Purely combinational; a running download owns the ROM store and CPU accesses are ignored meanwhile
`timescale 1ns/10ps
`include "gb_cart_defs.svh"

module rom_addr_map import gb_cart_pkg::*; (
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [15:0]             dl_data,
	input  logic [`CART_ADDR_W-1:0] cart_addr,
	input  logic                    cart_rd,
	input  mbc_kind_t               mbc_kind,
	input  logic [`ROM_BANK_W-1:0]  rom_bank,
	input  logic [`RAM_BANK_W-1:0]  ram_bank,
	input  logic                    mbc1_mode,
	input  logic [`ROM_BANK_W-1:0]  rom_mask,
	output logic [`ROM_WADDR_W-1:0] rom_addr,
	output logic [1:0]              rom_ds,
	output logic                    rom_oe,
	output logic                    rom_we,
	output logic [15:0]             rom_wdata
);

	logic                  in_cram;    // A000-BFFF goes to cartridge RAM
	logic [6:0]            mbc1_bank;  // RAM bank bits on top in mode 0
	logic [`ROM_BANK_W-1:0] eff_bank;
	logic [`ROM_BANK_W:0]  bank_field; // 8 KB half-bank index

	assign in_cram   = (cart_addr[15:13] == `CRAM_WINDOW);
	assign mbc1_bank = {mbc1_mode ? 2'b00 : ram_bank[1:0], rom_bank[4:0]};
	assign eff_bank  = ((mbc_kind == MBC_1) ? {2'b00, mbc1_bank} : rom_bank) & rom_mask;

	// --------------------
	// Bank field
	// --------------------
	always_comb begin
		if (mbc_kind == MBC_NONE)
			bank_field = {8'd0, cart_addr[14:13]};  // Flat 32 KB
		else if (cart_addr[15:14] == 2'b00)
			bank_field = {9'd0, cart_addr[13]};     // Fixed bank 0
		else if (cart_addr[15:14] == 2'b01)
			bank_field = {eff_bank, cart_addr[13]}; // Switchable bank
		else
			bank_field = '0;
	end

	// Download takes the store, CPU reads otherwise
	assign rom_addr  = dl_active ? dl_addr[`DL_ADDR_W-1:1]
	                             : {2'b00, bank_field, cart_addr[12:1]};
	assign rom_ds    = dl_active ? 2'b11 : {cart_addr[0], ~cart_addr[0]};
	assign rom_oe    = !dl_active && cart_rd && !in_cram;
	assign rom_we    = dl_active && dl_wr;
	assign rom_wdata = dl_active ? dl_data : 16'd0;

endmodule

// File: verilog/cart_ram.sv
// Single-port 128 KB RAM with one-cycle read; the clock registers of MBC3 are not modelled and read 00
`timescale 1ns/10ps
`include "gb_cart_defs.svh"

module cart_ram import gb_cart_pkg::*; (
	input  logic                    clk_sys,
	input  logic [`CART_ADDR_W-1:0] cart_addr,
	input  logic                    cart_rd,
	input  logic                    cart_wr,
	input  logic [7:0]              cart_di,
	input  mbc_kind_t               mbc_kind,
	input  logic [`RAM_BANK_W-1:0]  ram_bank,
	input  logic [`RAM_BANK_W-1:0]  ram_mask,
	input  logic                    mbc1_mode,
	input  logic                    rtc_mode,
	input  logic                    ram_enable,
	input  logic                    has_ram,
	output logic [7:0]              cram_q
);

	logic [7:0]              mem [0:(1 << `CRAM_ADDR_W) - 1];
	logic                    in_cram;
	logic                    flat_bank;   // Controller without RAM banking
	logic [`RAM_BANK_W-1:0]  bank_sel;
	logic [`CRAM_ADDR_W-1:0] cram_addr;
	logic                    cram_rd;
	logic                    cram_wr;

	// Read-side state captured with the data
	logic [7:0] mem_q;
	logic       off_q;    // RAM closed
	logic       rtc_q;    // MBC3 clock selected
	logic       nib_q;    // MBC2 4-bit cell

	assign in_cram   = (cart_addr[15:13] == `CRAM_WINDOW);
	assign flat_bank = (mbc_kind == MBC_NONE) || (mbc_kind == MBC_2) ||
	                   ((mbc_kind == MBC_1) && !mbc1_mode);
	assign bank_sel  = flat_bank ? '0 : (ram_bank & ram_mask);  // Mirrors small RAMs
	assign cram_addr = {bank_sel, cart_addr[12:0]};

	assign cram_rd = cart_rd && in_cram;
	assign cram_wr = cart_wr && in_cram && ram_enable && has_ram;

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (cram_wr)
			mem[cram_addr] <= cart_di;
	end

	// Value and flags hold until the next RAM read
	always_ff @(posedge clk_sys) begin
		if (cram_rd) begin
			mem_q <= mem[cram_addr];
			off_q <= !ram_enable;
			rtc_q <= rtc_mode;
			nib_q <= (mbc_kind == MBC_2) && (cart_addr[15:9] == 7'b1010000);  // A000-A1FF
		end
	end

	// --------------------
	// Read value
	// --------------------
	always_comb begin
		if (off_q)
			cram_q = 8'hFF;                 // Open bus
		else if (rtc_q)
			cram_q = 8'h00;
		else if (nib_q)
			cram_q = {4'hF, mem_q[3:0]};    // Upper nibble not wired on MBC2
		else
			cram_q = mem_q;
	end

endmodule

// File: verilog/cart_read_mux.sv
// Reads return 00 until the first download has finished; cart_do holds the last read byte
`timescale 1ns/10ps
`include "gb_cart_defs.svh"

module cart_read_mux (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,
	input  logic [`CART_ADDR_W-1:0] cart_addr,
	input  logic                    cart_rd,
	input  logic [15:0]             rom_data,
	input  logic [7:0]              cram_q,
	output logic [7:0]              cart_do
);

	logic       dl_active_q;  // For falling-edge detect
	logic       cart_ready;
	logic       ram_sel_q;    // Last read was in the RAM window
	logic [7:0] rom_byte_q;   // ROM half chosen by address bit 0

	// --------------------
	// Readiness and select
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			cart_ready  <= 1'b0;
			ram_sel_q   <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active_q && !dl_active)
				cart_ready <= 1'b1;  // Image fully in the store
			if (cart_rd)
				ram_sel_q <= (cart_addr[15:13] == `CRAM_WINDOW);
		end
	end

	// rom_data follows rom_addr, so it is sampled in the read cycle
	always_ff @(posedge clk_sys) begin
		if (cart_rd)
			rom_byte_q <= cart_addr[0] ? rom_data[15:8] : rom_data[7:0];
	end

	assign cart_do = !cart_ready ? 8'h00 :
	                 ram_sel_q   ? cram_q : rom_byte_q;

endmodule

// File: verilog/gb_cart.sv
// Cartridge side only; rom_data must return combinationally from rom_addr, ce_cpu2x gates register writes
`timescale 1ns/10ps
`include "gb_cart_defs.svh"

module gb_cart import gb_cart_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ce_cpu2x,
	// Download from host
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [15:0]             dl_data,
	// CPU bus
	input  logic [`CART_ADDR_W-1:0] cart_addr,
	input  logic                    cart_rd,
	input  logic                    cart_wr,
	input  logic [7:0]              cart_di,
	output logic [7:0]              cart_do,
	// External ROM store
	output logic [`ROM_WADDR_W-1:0] rom_addr,
	output logic [1:0]              rom_ds,
	output logic                    rom_oe,
	output logic                    rom_we,
	output logic [15:0]             rom_wdata,
	input  logic [15:0]             rom_data
);

	mbc_kind_t              mbc_kind;
	logic [`ROM_BANK_W-1:0] rom_mask;
	logic [`RAM_BANK_W-1:0] ram_mask;
	logic                   has_ram;
	logic [`ROM_BANK_W-1:0] rom_bank;
	logic [`RAM_BANK_W-1:0] ram_bank;
	logic                   mbc1_mode;
	logic                   rtc_mode;
	logic                   ram_enable;
	logic [7:0]             cram_q;

	// --------------------
	// Controller state
	// --------------------
	cart_header cart_header_inst (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_addr, .dl_data,
		.mbc_kind, .rom_mask, .ram_mask, .has_ram
	);

	mbc_bank_regs mbc_bank_regs_inst (
		.clk_sys, .reset, .ce_cpu2x, .cart_wr, .cart_addr, .cart_di, .mbc_kind,
		.rom_bank, .ram_bank, .mbc1_mode, .rtc_mode, .ram_enable
	);

	// --------------------
	// ROM and RAM paths
	// --------------------
	rom_addr_map rom_addr_map_inst (
		.dl_active, .dl_wr, .dl_addr, .dl_data, .cart_addr, .cart_rd,
		.mbc_kind, .rom_bank, .ram_bank, .mbc1_mode, .rom_mask,
		.rom_addr, .rom_ds, .rom_oe, .rom_we, .rom_wdata
	);

	cart_ram cart_ram_inst (
		.clk_sys, .cart_addr, .cart_rd, .cart_wr, .cart_di, .mbc_kind,
		.ram_bank, .ram_mask, .mbc1_mode, .rtc_mode, .ram_enable, .has_ram,
		.cram_q
	);

	cart_read_mux cart_read_mux_inst (
		.clk_sys, .reset, .dl_active, .cart_addr, .cart_rd, .rom_data, .cram_q,
		.cart_do  // Back to the CPU
	);

endmodule

// File: verification/gb_cart_asserts.sv
// Checks the ROM store strobes on every clk_sys edge outside reset; bound into gb_cart
`timescale 1ns/10ps

module gb_cart_asserts (
	input logic       clk_sys,
	input logic       reset,
	input logic       dl_active,
	input logic       rom_we,
	input logic       rom_oe,
	input logic [1:0] rom_ds
);

	// --------------------
	// ROM store strobes
	// --------------------
	we_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		rom_we |-> dl_active)
		else $error("rom_we high outside a download");

	no_oe_with_we: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_oe && rom_we))
		else $error("rom_oe and rom_we high together");

	// Host owns the store while loading
	no_oe_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		dl_active |-> !rom_oe)
		else $error("rom_oe high during a download");

	we_full_word: assert property (@(posedge clk_sys) disable iff (reset)
		rom_we |-> (rom_ds == 2'b11))
		else $error("rom_we without both byte selects");

endmodule

// File: verification/gb_cart_tb.sv
// ROM store is modelled as word address XOR A5C3; ce_cpu2x stays high, so every CPU store hits the registers
`timescale 1ns/10ps
`include "gb_cart_defs.svh"

module gb_cart_tb import gb_cart_pkg::*; ();

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 5;
	// Cycle budgets of the tests; the watchdog waits for their sum
	localparam int DL_CYCLES    = 60;
	localparam int HDR_CYCLES   = 300;
	localparam int BANK_CYCLES  = 100;
	localparam int RAM_CYCLES   = 200;
	localparam int MODE_CYCLES  = 100;
	localparam int LIMIT_CYCLES = RESET_CYCLES + DL_CYCLES + HDR_CYCLES + BANK_CYCLES +
	                              RAM_CYCLES + MODE_CYCLES + 100;  // Plus margin

	logic                    clk_sys, reset, ce_cpu2x;
	logic                    dl_active, dl_wr;
	logic [`DL_ADDR_W-1:0]   dl_addr;
	logic [15:0]             dl_data;
	logic [`CART_ADDR_W-1:0] cart_addr;
	logic                    cart_rd, cart_wr;
	logic [7:0]              cart_di, cart_do;
	logic [`ROM_WADDR_W-1:0] rom_addr;
	logic [1:0]              rom_ds;
	logic                    rom_oe, rom_we;
	logic [15:0]             rom_wdata, rom_data;

	integer seed   = 32'h7022;
	int     errors = 0;
	int     checks = 0;

	// Expected controller state from the header and register rules
	mbc_kind_t  m_kind     = MBC_NONE;
	logic [8:0] m_rom_bank = 9'd1;
	logic [8:0] m_rom_mask = 9'd1;   // Size code 0
	logic [3:0] m_ram_bank = 4'd0;
	logic [3:0] m_ram_mask = 4'd0;
	logic       m_mode     = 1'b0;
	logic       m_rtc      = 1'b0;
	logic       m_ram_en   = 1'b0;
	logic       m_has_ram  = 1'b0;
	logic [7:0] ram_model [0:(1 << `CRAM_ADDR_W) - 1];
	logic [23:0] wr_addr_q [$];      // Store writes seen on rom_we
	logic [15:0] wr_data_q [$];

	gb_cart gb_cart_inst (.*);

	bind gb_cart gb_cart_asserts gb_cart_asserts_inst (
		.clk_sys, .reset, .dl_active, .rom_we, .rom_oe, .rom_ds
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// --------------------
	// ROM store model
	// --------------------
	assign rom_data = rom_addr[15:0] ^ 16'hA5C3;

	always @(posedge clk_sys) begin
		if (rom_we) begin
			wr_addr_q.push_back(rom_addr);
			wr_data_q.push_back(rom_wdata);
		end
	end

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Timeout: tests still running after %0d cycles", LIMIT_CYCLES);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Test failures found");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
	                           input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
		end
	endtask

	// Type byte table of the cartridge header
	function automatic mbc_kind_t kind_of(input logic [7:0] t);
		if (t >= 8'h01 && t <= 8'h03) return MBC_1;
		if (t == 8'h05 || t == 8'h06) return MBC_2;
		if (t >= 8'h0F && t <= 8'h13) return MBC_3;
		if (t >= 8'h19 && t <= 8'h1E) return MBC_5;
		return MBC_NONE;
	endfunction

	function automatic logic [23:0] rom_word(input logic [15:0] a);
		logic [8:0] eff;
		logic [9:0] field;
		eff = (m_kind == MBC_1) ? {2'b00, m_mode ? 2'b00 : m_ram_bank[1:0], m_rom_bank[4:0]}
		                        : m_rom_bank;
		if (m_kind == MBC_NONE)
			field = {8'd0, a[14:13]};
		else if (a < 16'h4000)
			field = {9'd0, a[13]};           // Bank 0 always
		else
			field = {eff & m_rom_mask, a[13]};
		return {2'b00, field, a[12:1]};
	endfunction

	function automatic int ram_index(input logic [15:0] a);
		logic [3:0] bank;
		bank = m_ram_bank & m_ram_mask;
		if (m_kind == MBC_NONE || m_kind == MBC_2 || (m_kind == MBC_1 && !m_mode))
			bank = 4'd0;
		return {bank, a[12:0]};
	endfunction

	function automatic logic [7:0] ram_expect(input logic [15:0] a);
		if (!m_ram_en) return 8'hFF;
		if (m_rtc) return 8'h00;
		if (m_kind == MBC_2 && a < 16'hA200) return {4'hF, ram_model[ram_index(a)][3:0]};
		return ram_model[ram_index(a)];
	endfunction

	// --------------------
	// Bus tasks
	// --------------------
	task automatic dl_word(input logic [`DL_ADDR_W-1:0] addr, input logic [15:0] data);
		@(negedge clk_sys);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	task automatic load_header(input logic [7:0] type_code, input logic [7:0] rom_code,
	                           input logic [7:0] ram_code);
		@(negedge clk_sys);
		dl_active = 1'b1;
		dl_word(`HDR_TYPE_ADDR, {type_code, 8'($random(seed))});
		dl_word(`HDR_SIZE_ADDR, {ram_code, rom_code});
		@(negedge clk_sys);
		dl_active  = 1'b0;
		m_kind     = kind_of(type_code);
		m_rom_mask = (rom_code <= 8) ? 9'((1 << (rom_code + 1)) - 1) : 9'd127;
		m_ram_mask = (ram_code <= 2) ? 4'h0 : (ram_code == 3) ? 4'h3 : 4'hF;
		m_has_ram  = (ram_code != 0) || (m_kind == MBC_2);
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		cart_addr = a;
		cart_di   = d;
		cart_wr   = 1'b1;
		@(negedge clk_sys);
		cart_wr = 1'b0;
		if (a >= 16'hA000 && a < 16'hC000) begin
			if (m_ram_en && m_has_ram)
				ram_model[ram_index(a)] = d;
		end else if (!a[15]) begin
			case (a[14:13])
				2'd0: m_ram_en = (d[3:0] == `RAM_ENABLE_KEY);
				2'd1: begin
					if (m_kind != MBC_5)
						m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
					else if (a[12])
						m_rom_bank[8] = d[0];  // High bit at 3000-3FFF
					else
						m_rom_bank[7:0] = d;
				end
				2'd2: begin
					if (m_kind == MBC_3)
						m_rtc = d[3];
					if (m_kind == MBC_5)
						m_ram_bank = d[3:0];
					else if (!(m_kind == MBC_3 && d[3]))
						m_ram_bank = {2'b00, d[1:0]};
				end
				default: begin
					if (m_kind == MBC_1)
						m_mode = d[0];
				end
			endcase
		end
	endtask

	// One read with cart_do sampled a full cycle later
	task automatic read_check(input logic [15:0] a, input logic [7:0] exp_byte,
	                          input logic [23:0] exp_word, input logic check_word);
		@(negedge clk_sys);
		cart_addr = a;
		cart_rd   = 1'b1;
		#(CLK_PERIOD / 4);
		check_value("rom_oe", rom_oe, !dl_active && !(a >= 16'hA000 && a < 16'hC000));
		check_value("rom_ds", rom_ds, dl_active ? 2'b11 : (a[0] ? 2'b10 : 2'b01));
		if (check_word)
			check_value("rom_addr", rom_addr, exp_word);
		@(negedge clk_sys);
		cart_rd = 1'b0;
		check_value("cart_do", cart_do, exp_byte);
	endtask

	task automatic read_rom(input logic [15:0] a);
		logic [23:0] word_addr;
		logic [15:0] word;
		word_addr = rom_word(a);
		word      = word_addr[15:0] ^ 16'hA5C3;
		read_check(a, a[0] ? word[15:8] : word[7:0], word_addr, 1'b1);
	endtask

	task automatic read_ram(input logic [15:0] a);
		read_check(a, ram_expect(a), 24'd0, 1'b0);
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic download_path();
		int          first;
		logic [15:0] data [4];
		first = wr_addr_q.size();
		read_check(16'h0100, 8'h00, 24'd0, 1'b0);  // Not ready after reset
		@(negedge clk_sys);
		dl_active = 1'b1;
		for (int i = 0; i < 4; i++) begin
			data[i] = 16'($random(seed));
			dl_word(25'h200 + 25'(4 * i), data[i]);
		end
		read_check(16'h4001, 8'h00, 24'd0, 1'b0);  // Still loading
		@(negedge clk_sys);
		dl_active = 1'b0;
		check_value("store writes", wr_addr_q.size() - first, 4);
		for (int i = 0; i < 4; i++) begin
			check_value("rom_addr", wr_addr_q[first + i], 24'h100 + 24'(2 * i));
			check_value("rom_wdata", wr_data_q[first + i], data[i]);
		end
		read_rom(16'h0002);
		read_rom(16'h6003);  // Flat 32 KB
	endtask

	task automatic header_case(input logic [7:0] type_code, input logic [7:0] rom_code,
	                           input logic [8:0] bank);
		load_header(type_code, rom_code, 8'h00);
		cpu_write(16'h4000, 8'h00);     // MBC1 upper bits cleared
		cpu_write(16'h2000, bank[7:0]);
		if (kind_of(type_code) == MBC_5)
			cpu_write(16'h3000, {7'd0, bank[8]});
		read_rom(16'h4000 | (16'($random(seed)) & 16'h3FFF));
		read_rom(16'h4000 | (16'($random(seed)) & 16'h3FFF));
		read_rom(16'h7FFF);
		read_rom(16'($random(seed)) & 16'h3FFF);
	endtask

	task automatic header_decoding();
		header_case(8'h00, 8'h00, 9'h003);
		header_case(8'h01, 8'h02, 9'h01D);  // Mask 7
		header_case(8'h05, 8'h03, 9'h02B);
		header_case(8'h13, 8'h05, 9'h07F);
		header_case(8'h1B, 8'h08, 9'h1A5);  // Full 9 bits
		header_case(8'h1E, 8'h52, 9'h1F3);  // Odd size masked to 127
		header_case(8'h08, 8'h01, 9'h002);  // Unknown type
	endtask

	task automatic bank_register_rules();
		load_header(8'h03, 8'h06, 8'h03);
		cpu_write(16'h2000, 8'h00);         // Zero selects bank 1
		read_rom(16'h4000);
		cpu_write(16'h2000, 8'h03);
		cpu_write(16'h4000, 8'h02);         // Upper ROM bits in mode 0
		read_rom(16'h5AB1);
		cpu_write(16'h6000, 8'h01);
		read_rom(16'h5AB1);
		cpu_write(16'h6000, 8'h00);
		load_header(8'h19, 8'h08, 8'h00);
		cpu_write(16'h2000, 8'h34);
		cpu_write(16'h3000, 8'h01);         // Bank 134
		read_rom(16'h6F02);
		cpu_write(16'h2000, 8'h00);         // Bank 0 allowed on MBC5
		cpu_write(16'h3000, 8'h00);
		read_rom(16'h4123);
	endtask

	task automatic cart_ram_banking();
		logic [15:0] offs [3];
		load_header(8'h1B, 8'h04, 8'h03);   // Four RAM banks
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'hA000, 8'h11);
		cpu_write(16'h0000, 8'h00);
		read_ram(16'hA000);                 // Closed
		cpu_write(16'hA000, 8'h5A);         // Dropped
		cpu_write(16'h0000, 8'h0A);
		read_ram(16'hA000);
		for (int i = 0; i < 3; i++)
			offs[i] = 16'hA000 | (16'($random(seed)) & 16'h1FFF);
		for (int b = 0; b < 4; b++) begin
			cpu_write(16'h4000, 8'(b));
			for (int i = 0; i < 3; i++)
				cpu_write(offs[i], 8'($random(seed)));
		end
		for (int b = 0; b < 8; b++) begin   // Banks 4-7 mirror 0-3
			cpu_write(16'h4000, 8'(b));
			for (int i = 0; i < 3; i++)
				read_ram(offs[i]);
		end
	endtask

	task automatic mbc2_mbc3_modes();
		load_header(8'h06, 8'h01, 8'h00);   // Built-in RAM
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'hA010, 8'h5C);
		read_ram(16'hA010);
		cpu_write(16'hA1FF, 8'h93);
		read_ram(16'hA1FF);
		load_header(8'h10, 8'h03, 8'h03);
		cpu_write(16'h4000, 8'h02);
		cpu_write(16'hB456, 8'hC7);
		read_ram(16'hB456);
		cpu_write(16'h4000, 8'h08);         // Clock register selected
		read_ram(16'hB456);
		cpu_write(16'h4000, 8'h02);
		read_ram(16'hB456);
	endtask

	initial begin
		clk_sys   = 1'b0;
		reset     = 1'b1;
		ce_cpu2x  = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		cart_addr = '0;
		cart_rd   = 1'b0;
		cart_wr   = 1'b0;
		cart_di   = '0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		download_path();
		header_decoding();
		bank_register_rules();
		cart_ram_banking();
		mbc2_mbc3_modes();
		@(negedge clk_sys);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: gb_cart.f
+incdir+common
common/gb_cart_pkg.sv
verilog/cart_header.sv
mapper/mbc_bank_regs.sv
mapper/rom_addr_map.sv
verilog/cart_ram.sv
verilog/cart_read_mux.sv
verilog/gb_cart.sv
verification/gb_cart_asserts.sv
verification/gb_cart_tb.sv

// File: Bender.yml
package:
  name: gb_cart

sources:
  - include_dirs:
      - common
    files:
      - common/gb_cart_pkg.sv
      - verilog/cart_header.sv
      - mapper/mbc_bank_regs.sv
      - mapper/rom_addr_map.sv
      - verilog/cart_ram.sv
      - verilog/cart_read_mux.sv
      - verilog/gb_cart.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/gb_cart_asserts.sv
      - verification/gb_cart_tb.sv
